//--- compile.f
hw/image_stream_pkg.sv
hw/pixel_packer.sv
hw/credit_tx_fifo.sv
hw/image_pack_top.sv
testbench/credit_tx_fifo_chk.sv
testbench/tb_image_pack.sv

//--- Bender.yml
package:
  name: image_pack

sources:
  # Design, in compile order
  - hw/image_stream_pkg.sv
  - hw/pixel_packer.sv
  - hw/credit_tx_fifo.sv
  - hw/image_pack_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - testbench/credit_tx_fifo_chk.sv
      - testbench/tb_image_pack.sv

//--- testbench/tb_image_pack.sv
`timescale 1ns/100ps

module tb_image_pack;

   import image_stream_pkg::*;

   localparam int PIXEL_WIDTH = 10;
   localparam int FIFO_DEPTH  = 8;
   localparam int CREDITS     = 4;
   localparam int TIMEOUT     = 200;   // Cycles allowed for any single wait

   logic         clk;
   logic         resetb;
   logic         enable;
   logic         dvi;
   dtype_t       dtypei;
   word_t        datai;
   logic         credit_return;
   logic         out_valid;
   dtype_t       out_dtype;
   word_t        out_data;
   frame_count_t frame_count;
   logic         overflow;

   int   errors       = 0;
   int   timeouts     = 0;
   int   cycle_cnt    = 0;
   int   credit_delay = 2;
   int   seed         = 32'h369e;
   logic hold_credits = 1'b0;
   int   release_q[$];   // Cycle at which each owed credit goes back

   dtype_t exp_dtype[$];
   word_t  exp_data[$];
   dtype_t got_dtype[$];
   word_t  got_data[$];

   // Reference model of the packer
   packer_state_t m_state;
   header_addr_t  m_addr;
   frame_count_t  m_count;
   logic          m_sync;
   logic          m_flag;
   logic          m_phase;
   logic [7:0]    m_low;

   image_pack_top #(
      .PIXEL_WIDTH (PIXEL_WIDTH),
      .FIFO_DEPTH  (FIFO_DEPTH),
      .CREDITS     (CREDITS)
   ) u_dut (
      .clk           (clk),
      .resetb        (resetb),
      .enable        (enable),
      .dvi           (dvi),
      .dtypei        (dtypei),
      .datai         (datai),
      .credit_return (credit_return),
      .out_valid     (out_valid),
      .out_dtype     (out_dtype),
      .out_data      (out_data),
      .frame_count   (frame_count),
      .overflow      (overflow)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // Receiver samples mid-cycle, where out_valid is settled
   always @(negedge clk) begin
      if (resetb && out_valid) begin
         got_dtype.push_back(out_dtype);
         got_data.push_back(out_data);
         release_q.push_back(cycle_cnt + credit_delay);
      end
   end

   initial begin
      credit_return = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (!hold_credits && release_q.size() > 0 && release_q[0] <= cycle_cnt) begin
            void'(release_q.pop_front());
            credit_return = 1'b1;   // One pulse per credit
         end else begin
            credit_return = 1'b0;
         end
      end
   end

   task automatic compare_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic compare_dtype(input string name, input dtype_t exp, input dtype_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic compare_count(input string name, input frame_count_t exp,
                                input frame_count_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      end
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   // Applies one input word to the model, a marker acts under the old state
   task automatic model_step(input logic v, input dtype_t t, input word_t d);
      logic       pack;
      logic       rewrite;
      logic [7:0] msb;
      pack    = m_flag && (m_state == FRAME_DATA);
      rewrite = m_flag && (m_state == HEADER_DATA);
      msb     = d[PIXEL_WIDTH-1 -: 8];
      if (pack && v && t[3]) begin
         if (m_phase) begin
            exp_dtype.push_back(t);
            exp_data.push_back({msb, m_low});
         end else begin
            m_low = msb;
         end
         m_phase = ~m_phase;
      end else if (v) begin
         exp_dtype.push_back(t);
         if (rewrite && t == DTYPE_HEADER && m_addr == IMAGE_TYPE_ADDR) begin
            exp_data.push_back({d[15:5], 5'h10});   // 8-bit packed image type
         end else begin
            exp_data.push_back(d);
         end
      end
      if (pack) begin
         m_addr = '0;
      end else if (rewrite) begin
         if (v && t == DTYPE_HEADER) begin
            m_addr = m_addr + 1'b1;
         end
         m_phase = 1'b0;
      end else begin
         m_phase = 1'b0;
         m_addr  = '0;
      end
      if (v) begin
         case (t)
            DTYPE_FRAME_START: begin
               m_state = FRAME_DATA;
               m_flag  = m_sync;
               m_count = m_count + 1'b1;
            end
            DTYPE_HEADER_START: m_state = HEADER_DATA;
            DTYPE_FRAME_END, DTYPE_HEADER_END: m_state = IDLE;
            default: ;
         endcase
      end
      m_sync = enable;
   endtask

   task automatic drive_cycle(input logic v, input dtype_t t, input word_t d);
      dvi    = v;
      dtypei = t;
      datai  = d;
      model_step(v, t, d);
      @(posedge clk);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, '0, '0);
   endtask

   task automatic send_pixels(input int n);
      repeat (n) drive_cycle(1'b1, dtype_t'(8 + $urandom % 8), word_t'($urandom & 16'h03ff));
   endtask

   task automatic send_header(input int n);
      drive_cycle(1'b1, DTYPE_HEADER_START, word_t'($urandom));
      repeat (n) drive_cycle(1'b1, DTYPE_HEADER, word_t'($urandom));
      drive_cycle(1'b1, DTYPE_HEADER_END, word_t'($urandom));
   endtask

   task automatic send_frame(input int n_pix, input int n_hdr);
      drive_cycle(1'b1, DTYPE_FRAME_START, word_t'($urandom));
      send_pixels(n_pix);
      drive_cycle(1'b1, DTYPE_FRAME_END, word_t'($urandom));
      send_header(n_hdr);
   endtask

   task automatic wait_words(input string test_name, input int n);
      int waited;
      waited = 0;
      while (got_data.size() < n && waited < TIMEOUT) begin
         idle_cycles(1);
         waited++;
      end
      if (got_data.size() < n) begin
         timeouts++;
         $display("Timeout in %s: %0d of %0d words arrived", test_name, got_data.size(), n);
      end
   endtask

   task automatic check_stream(input string test_name);
      int waited;
      wait_words(test_name, exp_data.size());
      idle_cycles(4);   // Extra words would show up here
      if (got_data.size() != exp_data.size()) begin
         errors++;
         $display("%s received %0d words where %0d were expected",
                  test_name, got_data.size(), exp_data.size());
      end
      for (int i = 0; i < got_data.size() && i < exp_data.size(); i++) begin
         compare_dtype("out_dtype", exp_dtype[i], got_dtype[i]);
         compare_word("out_data", exp_data[i], got_data[i]);
      end
      exp_dtype.delete();
      exp_data.delete();
      got_dtype.delete();
      got_data.delete();
      waited = 0;
      while (release_q.size() > 0 && waited < TIMEOUT) begin
         idle_cycles(1);
         waited++;
      end
      if (release_q.size() > 0) begin
         timeouts++;
         $display("Timeout in %s: credits were not all given back", test_name);
      end
      idle_cycles(2);
      compare_count("frame_count", m_count, frame_count);
   endtask

   task automatic test_passthrough();
      enable = 1'b0;
      idle_cycles(2);
      send_frame(8, 5);
      send_frame(6, 3);
      check_stream("passthrough");
   endtask

   task automatic test_packing();
      enable = 1'b1;
      idle_cycles(3);
      send_frame(12, 2);
      check_stream("packing");
   endtask

   task automatic test_header_rewrite();
      credit_delay = 4;   // Slower receiver, so the FIFO holds a small backlog
      send_frame(4, 6);
      send_frame(2, 3);   // Image type is the last header word here
      check_stream("header rewrite");
      credit_delay = 2;
   endtask

   task automatic test_enable_boundary();
      enable = 1'b0;
      idle_cycles(3);
      send_frame(4, 3);
      drive_cycle(1'b1, DTYPE_FRAME_START, word_t'($urandom));
      send_pixels(4);
      enable = 1'b1;
      send_pixels(4);
      drive_cycle(1'b1, DTYPE_FRAME_END, word_t'($urandom));
      send_header(3);
      send_frame(6, 4);
      check_stream("enable boundary");
   endtask

   task automatic test_backpressure();
      hold_credits = 1'b1;
      send_pixels(CREDITS + FIFO_DEPTH);
      wait_words("backpressure", CREDITS);
      idle_cycles(8);
      if (got_data.size() != CREDITS) begin
         errors++;
         $display("Back-pressure let %0d words through with %0d credits granted",
                  got_data.size(), CREDITS);
      end
      hold_credits = 1'b0;
      check_stream("backpressure");
      compare_flag("overflow", 1'b0, overflow);
   endtask

   task automatic test_overflow();
      hold_credits = 1'b1;
      send_pixels(CREDITS + FIFO_DEPTH + 8);
      wait_words("overflow", CREDITS);
      idle_cycles(4);
      compare_flag("overflow", 1'b1, overflow);
      while (exp_data.size() > CREDITS + FIFO_DEPTH) begin
         void'(exp_dtype.pop_back());
         void'(exp_data.pop_back());
      end
      hold_credits = 1'b0;
      check_stream("overflow");
      idle_cycles(10);
      compare_flag("overflow", 1'b1, overflow);
   endtask

   initial begin
      void'($urandom(seed));
      resetb  = 1'b0;
      enable  = 1'b0;
      dvi     = 1'b0;
      dtypei  = '0;
      datai   = '0;
      m_state = IDLE;
      m_addr  = '0;
      m_count = '0;
      m_sync  = 1'b0;
      m_flag  = 1'b0;
      m_phase = 1'b0;
      m_low   = '0;
      repeat (4) @(posedge clk);
      #1;
      resetb = 1'b1;

      test_passthrough();
      test_packing();
      test_header_rewrite();
      test_enable_boundary();
      test_backpressure();
      test_overflow();

      errors = errors + u_dut.u_tx_fifo.u_chk.assert_fails;
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- testbench/credit_tx_fifo_chk.sv
`timescale 1ns/100ps

module credit_tx_fifo_chk #(
   parameter int CREDITS = 4
) (
   input logic                      clk,
   input logic                      resetb,
   input logic                      out_valid,
   input logic                      credit_return,
   input image_stream_pkg::credit_t credit_count,
   input logic                      overflow
);

   import image_stream_pkg::*;

   int      assert_fails = 0;   // Read by the testbench at the end of the run
   credit_t held;               // Credits held, counted from the handshake pins alone

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         held <= credit_t'(CREDITS);
      end else if (out_valid && !credit_return) begin
         held <= held - 1'b1;
      end else if (credit_return && !out_valid) begin
         held <= held + 1'b1;
      end
   end

   // A word may only leave against a credit that is still held
   send_needs_credit: assert property (@(posedge clk) disable iff (!resetb)
      out_valid |-> (held != '0))
      else begin
         $error("out_valid raised while the credit count is zero");
         assert_fails++;
      end

   overflow_sticky: assert property (@(posedge clk) disable iff (!resetb)
      overflow |=> overflow)
      else begin
         $error("overflow dropped without a reset");
         assert_fails++;
      end

   // Returned credits can never exceed what the receiver granted at reset
   credit_bounded: assert property (@(posedge clk) disable iff (!resetb)
      credit_count <= CREDITS)
      else begin
         $error("credit count %0d is above the %0d granted at reset", credit_count, CREDITS);
         assert_fails++;
      end

endmodule

bind credit_tx_fifo credit_tx_fifo_chk #(
   .CREDITS (CREDITS)
) u_chk (
   .clk           (clk),
   .resetb        (resetb),
   .out_valid     (out_valid),
   .credit_return (credit_return),
   .credit_count  (credit_count),
   .overflow      (overflow)
);

//--- hw/image_pack_top.sv
`timescale 1ns/100ps

module image_pack_top #(
   parameter int PIXEL_WIDTH = 10,
   parameter int FIFO_DEPTH  = 8,
   parameter int CREDITS     = 4
) (
   input  logic                           clk,
   input  logic                           resetb,
   input  logic                           enable,
   input  logic                           dvi,
   input  image_stream_pkg::dtype_t       dtypei,
   input  image_stream_pkg::word_t        datai,
   input  logic                           credit_return,
   output logic                           out_valid,
   output image_stream_pkg::dtype_t       out_dtype,
   output image_stream_pkg::word_t        out_data,
   output image_stream_pkg::frame_count_t frame_count,
   output logic                           overflow
);

   import image_stream_pkg::*;

   // Packer output, one strobe per word handed to the FIFO
   logic   pk_valid;
   dtype_t pk_dtype;
   word_t  pk_data;

   pixel_packer #(
      .PIXEL_WIDTH (PIXEL_WIDTH)
   ) u_packer (
      .clk         (clk),
      .resetb      (resetb),
      .enable      (enable),
      .dvi         (dvi),
      .dtypei      (dtypei),
      .datai       (datai),
      .pk_valid    (pk_valid),
      .pk_dtype    (pk_dtype),
      .pk_data     (pk_data),
      .frame_count (frame_count)
   );

   credit_tx_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .CREDITS    (CREDITS)
   ) u_tx_fifo (
      .clk           (clk),
      .resetb        (resetb),
      .in_valid      (pk_valid),
      .in_dtype      (pk_dtype),
      .in_data       (pk_data),
      .credit_return (credit_return),
      .out_valid     (out_valid),
      .out_dtype     (out_dtype),
      .out_data      (out_data),
      .overflow      (overflow)
   );

endmodule

//--- hw/credit_tx_fifo.sv
`timescale 1ns/100ps

module credit_tx_fifo #(
   parameter int FIFO_DEPTH = 8,
   parameter int CREDITS    = 4
) (
   input  logic                     clk,
   input  logic                     resetb,
   input  logic                     in_valid,
   input  image_stream_pkg::dtype_t in_dtype,
   input  image_stream_pkg::word_t  in_data,
   input  logic                     credit_return,
   output logic                     out_valid,
   output image_stream_pkg::dtype_t out_dtype,
   output image_stream_pkg::word_t  out_data,
   output logic                     overflow
);

   import image_stream_pkg::*;

   localparam int ADDR_W = $clog2(FIFO_DEPTH);

   // Pointers carry one extra bit to tell full from empty
   logic [ADDR_W:0] wr_ptr;
   logic [ADDR_W:0] rd_ptr;

   dtype_t dtype_mem [FIFO_DEPTH];
   word_t  data_mem  [FIFO_DEPTH];

   credit_t credit_count;

   logic empty;
   logic full;
   logic wr_en;
   logic send;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   // The source cannot be held off, so a word that finds the buffer full is lost
   assign wr_en = in_valid && !full;

   // A word leaves only when one is stored and the receiver has room for it
   assign send = !empty && (credit_count != '0);

   assign out_valid = send;
   assign out_dtype = dtype_mem[rd_ptr[ADDR_W-1:0]];
   assign out_data  = data_mem[rd_ptr[ADDR_W-1:0]];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         dtype_mem[wr_ptr[ADDR_W-1:0]] <= in_dtype;
         data_mem[wr_ptr[ADDR_W-1:0]]  <= in_data;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         wr_ptr <= '0;
      end else if (wr_en) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         rd_ptr <= '0;
      end else if (send) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // The receiver grants CREDITS slots at reset and hands them back one pulse at a time
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         credit_count <= credit_t'(CREDITS);
      end else begin
         case ({credit_return, send})
            2'b10:   credit_count <= credit_count + 1'b1;
            2'b01:   credit_count <= credit_count - 1'b1;
            default: credit_count <= credit_count;   // Send and return cancel out
         endcase
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         overflow <= 1'b0;
      end else if (in_valid && full) begin
         overflow <= 1'b1;   // Held until the next reset
      end
   end

endmodule

//--- hw/pixel_packer.sv
`timescale 1ns/100ps

module pixel_packer #(
   parameter int PIXEL_WIDTH = 10
) (
   input  logic                           clk,
   input  logic                           resetb,
   input  logic                           enable,
   input  logic                           dvi,
   input  image_stream_pkg::dtype_t       dtypei,
   input  image_stream_pkg::word_t        datai,
   output logic                           pk_valid,
   output image_stream_pkg::dtype_t       pk_dtype,
   output image_stream_pkg::word_t        pk_data,
   output image_stream_pkg::frame_count_t frame_count
);

   import image_stream_pkg::*;

   packer_state_t state;
   header_addr_t  header_addr;
   logic          enable_s;      // Enable after the first synchroniser flop
   logic          enable_flag;   // Enable as latched at the last frame start
   logic          phase;         // High while waiting for the second pixel of a pair

   logic          pixel_in;
   logic          header_word_in;
   logic          pack_mode;
   logic          rewrite_mode;
   logic [7:0]    pixel_msb;

   assign pixel_in       = dvi && ((dtypei & DTYPE_PIXEL_MASK) != '0);
   assign header_word_in = dvi && (dtypei == DTYPE_HEADER);
   assign pack_mode      = enable_flag && (state == FRAME_DATA);
   assign rewrite_mode   = enable_flag && (state == HEADER_DATA);

   // Top 8 bits of the pixel, whatever its width
   assign pixel_msb = datai[PIXEL_WIDTH-1 -: 8];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         state       <= IDLE;
         enable_s    <= 1'b0;
         enable_flag <= 1'b0;
         frame_count <= '0;
         phase       <= 1'b0;
         header_addr <= '0;
         pk_valid    <= 1'b0;
      end else begin
         enable_s <= enable;

         // Markers are handled under the old state, the new one applies from the next word
         if (dvi) begin
            if (dtypei == DTYPE_FRAME_START) begin
               state       <= FRAME_DATA;
               enable_flag <= enable_s;
               frame_count <= frame_count + 1'b1;
            end else if (dtypei == DTYPE_HEADER_START) begin
               state <= HEADER_DATA;
            end else if (dtypei == DTYPE_FRAME_END || dtypei == DTYPE_HEADER_END) begin
               state <= IDLE;
            end
         end

         if (pack_mode) begin
            if (pixel_in) begin
               pk_valid <= phase;    // Strobe only once the pair is complete
               phase    <= ~phase;
            end else begin
               pk_valid <= dvi;
            end
            header_addr <= '0;
         end else if (rewrite_mode) begin
            if (header_word_in) begin
               header_addr <= header_addr + 1'b1;
            end
            pk_valid <= dvi;
            phase    <= 1'b0;
         end else begin
            pk_valid    <= dvi;
            phase       <= 1'b0;
            header_addr <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      pk_dtype <= dtypei;

      if (pack_mode && pixel_in) begin
         // First pixel of a pair lands in the low byte
         if (phase) begin
            pk_data[15:8] <= pixel_msb;
         end else begin
            pk_data[7:0] <= pixel_msb;
         end
      end else if (rewrite_mode && header_word_in && header_addr == IMAGE_TYPE_ADDR) begin
         pk_data <= (datai & IMAGE_TYPE_MASK) | IMAGE_TYPE_PACKED8;
      end else begin
         pk_data <= datai;
      end
   end

endmodule

//--- hw/image_stream_pkg.sv
package image_stream_pkg;

   // Type tag that travels with every word of the stream
   typedef logic [3:0] dtype_t;

   // Stream data word
   typedef logic [15:0] word_t;

   // Frame counter, wraps silently
   typedef logic [15:0] frame_count_t;

   // Position of a word inside the header
   typedef logic [5:0] header_addr_t;

   // Credits held by the transmitter
   typedef logic [3:0] credit_t;

   // Data-type codes of the capture stream
   localparam dtype_t DTYPE_FRAME_START  = 4'd1;
   localparam dtype_t DTYPE_FRAME_END    = 4'd2;
   localparam dtype_t DTYPE_HEADER_START = 4'd3;
   localparam dtype_t DTYPE_HEADER       = 4'd4;
   localparam dtype_t DTYPE_HEADER_END   = 4'd5;

   // Bit 3 marks a pixel, codes 8 to 15 are all pixel types
   localparam dtype_t DTYPE_PIXEL_MASK = 4'b1000;

   // The image-type field is the third header word
   localparam header_addr_t IMAGE_TYPE_ADDR = 6'd2;

   // Low 5 bits hold the image-type code, the upper bits are kept
   localparam word_t IMAGE_TYPE_MASK = 16'hFFE0;

   // Code 0x10 marks the image as 8-bit packed
   localparam word_t IMAGE_TYPE_PACKED8 = 16'h0010;

   // Where the packer is within the stream
   typedef enum logic [1:0] {
      IDLE        = 2'd0,
      FRAME_DATA  = 2'd2,
      HEADER_DATA = 2'd3
   } packer_state_t;

endpackage
